// ==== logic/fp_format_pkg.sv ====
// Single-precision format definitions
package fp_format_pkg;

    localparam int FP_WIDTH     = 32;
    localparam int FP_EXP_WIDTH = 8;
    localparam int FP_MAN_WIDTH = 23;

    // IEEE 754 binary32, sign in bit 31
    typedef struct packed {
        logic                    sign;
        logic [FP_EXP_WIDTH-1:0] exponent;
        logic [FP_MAN_WIDTH-1:0] mantissa;
    } fp32_t;

    // Exception flags in fflags order
    typedef struct packed {
        logic nv; // Invalid operation
        logic dz; // Divide by zero
        logic of; // Overflow
        logic uf; // Underflow
        logic nx; // Inexact
    } fp_status_t;

    // Canonical quiet NaN
    localparam logic [FP_WIDTH-1:0] FP_CANON_NAN = 32'h7FC0_0000;

    localparam int FP_QNAN_BIT = FP_MAN_WIDTH - 1; // Set for quiet, clear for signaling

    // All-ones exponent, Inf or NaN
    localparam logic [FP_EXP_WIDTH-1:0] FP_EXP_MAX = '1;

endpackage

// ==== logic/fpx_pipe_pkg.sv ====
// FP completion path types
package fpx_pipe_pkg;

    localparam int PFPQ_NUM_ENTRIES = 4;
    localparam int PFPQ_PTR_WIDTH   = $clog2(PFPQ_NUM_ENTRIES);
    localparam int TAG_WIDTH        = 3;  // Wider than the queue index
    localparam int LONG_LATENCY     = 3;  // Min/max pipeline depth
    localparam int REG_ADDR_WIDTH   = 5;

    // Supported operations
    typedef enum logic [2:0] {
        FSGNJ  = 3'd0,
        FSGNJN = 3'd1,
        FSGNJX = 3'd2,
        FMIN   = 3'd3,
        FMAX   = 3'd4
    } fp_op_e;

    typedef logic [TAG_WIDTH-1:0] fpx_tag_t;

    // Request with operands already read
    typedef struct packed {
        logic                      valid;
        fp_op_e                    op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        fp_format_pkg::fp32_t      rs1;
        fp_format_pkg::fp32_t      rs2;
    } fpx_req_t;

    // Queue entry, result filled on completion
    typedef struct packed {
        fpx_req_t                           req;
        fpx_tag_t                           tag;
        logic [fp_format_pkg::FP_WIDTH-1:0] result;
    } fpx_instr_t;

    // Tagged result from the unit
    typedef struct packed {
        logic                               valid;
        fpx_tag_t                           tag;
        logic [fp_format_pkg::FP_WIDTH-1:0] data;
        fp_format_pkg::fp_status_t          status;
    } fpx_result_t;

endpackage

// ==== logic/fp_issue_stage.sv ====
// FP issue register
module fp_issue_stage (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,

    input  logic                     req_valid_i,   // Request offered
    input  fpx_pipe_pkg::fpx_req_t   req_i,
    output logic                     ready_o,       // Request taken this edge

    input  fpx_pipe_pkg::fpx_tag_t   tag_i,         // Next tag from the queue
    input  logic                     queue_full_i,
    input  logic                     unit_ready_i,

    output logic                     issue_valid_o, // Queue and unit take it together
    output fpx_pipe_pkg::fpx_instr_t issue_o
);
    import fpx_pipe_pkg::*;

    logic     valid_q;
    fpx_req_t req_q;
    logic     drain;
    logic     accept;

    // Both consumers agree on the same edge
    assign drain         = valid_q & ~queue_full_i & unit_ready_i;
    assign issue_valid_o = drain;

    // Empty or leaving, never during flush
    assign ready_o = ~flush_i & (~valid_q | drain);
    assign accept  = req_valid_i & ready_o;

    // Tag stamped as the entry leaves
    always_comb begin
        issue_o           = '0;
        issue_o.req       = req_q;
        issue_o.req.valid = valid_q;
        issue_o.tag       = tag_i;
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;       // Drop the held request
        end else if (accept) begin
            valid_q <= 1'b1;       // Refill, possibly while draining
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    // Operands and opcode
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

endmodule

// ==== logic/fp_exec_unit.sv ====
// FP sign injection and min/max unit
module fp_exec_unit (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      issue_valid_i,
    input  fpx_pipe_pkg::fpx_instr_t  issue_i,
    output logic                      unit_ready_o,  // Low on a result slot clash
    output fpx_pipe_pkg::fpx_result_t result_o
);
    import fp_format_pkg::*;
    import fpx_pipe_pkg::*;

    fp32_t      rs1, rs2, sgnj_res;
    logic       issue_short, accept_short, accept_long;
    logic       short_valid_q;     // Sign injection result
    fpx_tag_t   short_tag_q;
    fp32_t      short_data_q;
    logic       d_valid_q, d_max_q, d_a_nan_q, d_b_nan_q, d_nv_q;   // Decode
    fpx_tag_t   d_tag_q;
    fp32_t      d_a_q, d_b_q;
    logic       c_valid_q, c_pick_a_q, c_canon_q, c_nv_q;           // Compare
    fpx_tag_t   c_tag_q;
    fp32_t      c_a_q, c_b_q;
    logic       s_valid_q;                                          // Select
    fpx_tag_t   s_tag_q;
    fp32_t      s_data_q;
    fp_status_t s_status_q;
    logic       a_lt_b, pick_a;

    function automatic logic is_nan(input fp32_t x);
        return (x.exponent == FP_EXP_MAX) && (x.mantissa != '0);
    endfunction

    function automatic logic is_snan(input fp32_t x);
        return is_nan(x) && !x.mantissa[FP_QNAN_BIT];
    endfunction

    assign rs1         = issue_i.req.rs1;
    assign rs2         = issue_i.req.rs2;
    assign issue_short = issue_i.req.op inside {FSGNJ, FSGNJN, FSGNJX};

    // A long op in compare leaves next edge, same slot as a new short one
    assign unit_ready_o = ~(issue_i.req.valid & issue_short & c_valid_q);
    assign accept_short = issue_valid_i & issue_i.req.valid & issue_short & unit_ready_o;
    assign accept_long  = issue_valid_i & issue_i.req.valid & ~issue_short;

    // Magnitude of rs1, sign by rule
    always_comb begin
        sgnj_res = rs1;
        case (issue_i.req.op)
            FSGNJ:   sgnj_res.sign = rs2.sign;
            FSGNJN:  sgnj_res.sign = ~rs2.sign;
            default: sgnj_res.sign = rs1.sign ^ rs2.sign;
        endcase
    end

    // Sign-magnitude ordering, -0 below +0
    always_comb begin
        if (d_a_q.sign != d_b_q.sign) begin
            a_lt_b = d_a_q.sign;
        end else if (d_a_q.sign) begin
            a_lt_b = {d_a_q.exponent, d_a_q.mantissa} > {d_b_q.exponent, d_b_q.mantissa};
        end else begin
            a_lt_b = {d_a_q.exponent, d_a_q.mantissa} < {d_b_q.exponent, d_b_q.mantissa};
        end
        if (d_a_nan_q) pick_a = 1'b0;       // Other operand wins
        else if (d_b_nan_q) pick_a = 1'b1;
        else pick_a = d_max_q ? ~a_lt_b : a_lt_b;
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            short_valid_q <= 1'b0;
            d_valid_q     <= 1'b0;
            c_valid_q     <= 1'b0;
            s_valid_q     <= 1'b0;
        end else if (flush_i) begin
            short_valid_q <= 1'b0;
            d_valid_q     <= 1'b0;
            c_valid_q     <= 1'b0;
            s_valid_q     <= 1'b0;
        end else begin
            short_valid_q <= accept_short;
            d_valid_q     <= accept_long;
            c_valid_q     <= d_valid_q;
            s_valid_q     <= c_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        short_tag_q  <= issue_i.tag;
        short_data_q <= sgnj_res;
        d_tag_q      <= issue_i.tag;
        d_max_q      <= (issue_i.req.op == FMAX);
        d_a_q        <= rs1;
        d_b_q        <= rs2;
        d_a_nan_q    <= is_nan(rs1);
        d_b_nan_q    <= is_nan(rs2);
        d_nv_q       <= is_snan(rs1) | is_snan(rs2);  // Signaling input
        c_tag_q      <= d_tag_q;
        c_a_q        <= d_a_q;
        c_b_q        <= d_b_q;
        c_pick_a_q   <= pick_a;
        c_canon_q    <= d_a_nan_q & d_b_nan_q;
        c_nv_q       <= d_nv_q;
        s_tag_q      <= c_tag_q;
        s_data_q     <= c_canon_q ? fp32_t'(FP_CANON_NAN) : (c_pick_a_q ? c_a_q : c_b_q);
        s_status_q   <= '{nv: c_nv_q, default: 1'b0};
    end

    // One result per cycle, short path first
    always_comb begin
        result_o = '0;
        if (short_valid_q) begin
            result_o.valid = 1'b1;
            result_o.tag   = short_tag_q;
            result_o.data  = short_data_q;   // Status stays zero
        end else if (s_valid_q) begin
            result_o.valid  = 1'b1;
            result_o.tag    = s_tag_q;
            result_o.data   = s_data_q;
            result_o.status = s_status_q;
        end
    end

    a_no_result_clash: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(short_valid_q && s_valid_q));

endmodule

// ==== logic/pending_fp_ops_queue.sv ====
// In-order completion queue for FP operations
module pending_fp_ops_queue (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               flush_i,            // Drop all entries

    input  logic                               valid_i,            // New entry offered
    input  fpx_pipe_pkg::fpx_instr_t           instruction_i,

    input  logic                               result_valid_i,
    input  fpx_pipe_pkg::fpx_tag_t             result_tag_i,       // Which entry finished
    input  logic [fp_format_pkg::FP_WIDTH-1:0] result_data_i,
    input  fp_format_pkg::fp_status_t          result_fp_status_i,
    input  logic                               advance_head_i,     // Head retired

    output fpx_pipe_pkg::fpx_instr_t           finish_instr_fp_o,  // Done head, else zero
    output fp_format_pkg::fp_status_t          finish_fp_status_o,

    output fpx_pipe_pkg::fpx_tag_t             tag_o,              // Tag for the next entry
    output logic                               full_o
);
    import fp_format_pkg::*;
    import fpx_pipe_pkg::*;

    typedef logic [PFPQ_PTR_WIDTH-1:0] pfpq_ptr_t;
    typedef logic [PFPQ_PTR_WIDTH:0]   pfpq_cnt_t;  // One bit over the pointer

    fpx_tag_t  tag_int;
    pfpq_ptr_t head;  // Oldest entry
    pfpq_ptr_t tail;  // Next free slot
    pfpq_cnt_t num;

    logic write_enable;
    logic advance_head_enable;
    logic head_done;
    logic result_hit;
    logic [PFPQ_NUM_ENTRIES-1:0] tag_match;

    // Entry storage
    fpx_instr_t instr_table  [PFPQ_NUM_ENTRIES];
    fp_status_t status_table [PFPQ_NUM_ENTRIES];
    fpx_tag_t   tag_table    [PFPQ_NUM_ENTRIES];
    logic [PFPQ_NUM_ENTRIES-1:0] live_q;  // Slot holds an operation
    logic [PFPQ_NUM_ENTRIES-1:0] done_q;  // Result arrived

    assign tag_o = tag_int;

    assign write_enable        = valid_i & instruction_i.req.valid & (num < PFPQ_NUM_ENTRIES);
    assign advance_head_enable = advance_head_i & (num != '0);

    // Associative lookup on the returning tag
    always_comb begin
        for (int j = 0; j < PFPQ_NUM_ENTRIES; j++) begin
            tag_match[j] = live_q[j] && (tag_table[j] == result_tag_i);
        end
    end
    assign result_hit = |tag_match;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head    <= '0;
            tail    <= '0;
            num     <= '0;
            tag_int <= '0;
            live_q  <= '0;
            done_q  <= '0;
        end else if (flush_i) begin
            head    <= '0;
            tail    <= '0;
            num     <= '0;
            tag_int <= '0;     // Tags restart after a flush
            live_q  <= '0;
            done_q  <= '0;
        end else begin
            head    <= head + pfpq_ptr_t'(advance_head_enable);
            tail    <= tail + pfpq_ptr_t'(write_enable);
            num     <= num + pfpq_cnt_t'(write_enable) - pfpq_cnt_t'(advance_head_enable);
            tag_int <= tag_int + fpx_tag_t'(write_enable);
            if (write_enable) begin
                live_q[tail] <= 1'b1;
                done_q[tail] <= 1'b0;
            end
            for (int j = 0; j < PFPQ_NUM_ENTRIES; j++) begin
                if (result_valid_i && tag_match[j]) done_q[j] <= 1'b1;
            end
            if (advance_head_enable) begin
                live_q[head] <= 1'b0;
                done_q[head] <= 1'b0;
            end
        end
    end

    // Payload, qualified by live_q
    always_ff @(posedge clk_i) begin
        if (write_enable) begin
            instr_table[tail] <= instruction_i;
            tag_table[tail]   <= tag_int;
        end
        for (int j = 0; j < PFPQ_NUM_ENTRIES; j++) begin
            if (result_valid_i && tag_match[j]) begin
                instr_table[j].result <= result_data_i;
                status_table[j]       <= result_fp_status_i;
            end
        end
    end

    // Head shown only once its result is in
    assign head_done          = (num != '0) && done_q[head];
    assign finish_instr_fp_o  = head_done ? instr_table[head] : '0;
    assign finish_fp_status_o = head_done ? status_table[head] : '0;

    assign full_o = (num >= PFPQ_NUM_ENTRIES) | flush_i;

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        num <= PFPQ_NUM_ENTRIES);

    a_no_advance_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        advance_head_i |-> (num != '0));

    // Every unit result belongs to an operation still held here
    a_result_has_owner: assert property (@(posedge clk_i) disable iff (!rstn_i)
        result_valid_i |-> result_hit);

endmodule

// ==== logic/fp_writeback_stage.sv ====
// FP writeback and sticky flags
module fp_writeback_stage (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  logic                                     flush_i,

    input  fpx_pipe_pkg::fpx_instr_t                 finish_instr_i,  // Done head or zero
    input  fp_format_pkg::fp_status_t                finish_status_i,
    output logic                                     advance_head_o,

    output logic                                     wb_valid_o,      // One pulse per retire
    output logic [fpx_pipe_pkg::REG_ADDR_WIDTH-1:0]  wb_rd_o,
    output logic [fp_format_pkg::FP_WIDTH-1:0]       wb_data_o,
    output fp_format_pkg::fp_status_t                wb_status_o,
    output fp_format_pkg::fp_status_t                fflags_o         // Accumulated flags
);

    logic retire;

    // Flushed work never reaches writeback
    assign retire         = finish_instr_i.req.valid & ~flush_i;
    assign advance_head_o = retire;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_o <= 1'b0;
            fflags_o   <= '0;
        end else begin
            wb_valid_o <= retire;
            if (retire) begin
                fflags_o <= fflags_o | finish_status_i;  // Sticky, survives flush
            end
        end
    end

    // Writeback port payload
    always_ff @(posedge clk_i) begin
        if (retire) begin
            wb_rd_o     <= finish_instr_i.req.rd;
            wb_data_o   <= finish_instr_i.result;
            wb_status_o <= finish_status_i;
        end
    end

endmodule

// ==== logic/fp_exec_top.sv ====
// FP completion path top level
module fp_exec_top (
    input  logic                                    clk_i,
    input  logic                                    rstn_i,
    input  logic                                    flush_i,
    input  logic                                    req_valid_i,
    input  fpx_pipe_pkg::fpx_req_t                  req_i,
    output logic                                    ready_o,
    output logic                                    wb_valid_o,
    output logic [fpx_pipe_pkg::REG_ADDR_WIDTH-1:0] wb_rd_o,
    output logic [fp_format_pkg::FP_WIDTH-1:0]      wb_data_o,
    output fp_format_pkg::fp_status_t               wb_status_o,
    output fp_format_pkg::fp_status_t               fflags_o
);
    import fp_format_pkg::*;
    import fpx_pipe_pkg::*;

    logic        issue_valid;   // Queue and unit take the entry
    fpx_instr_t  issue;
    logic        unit_ready;
    logic        queue_full;
    fpx_tag_t    next_tag;
    fpx_result_t result;        // Out of order from the unit
    fpx_instr_t  finish_instr;  // In order to writeback
    fp_status_t  finish_status;
    logic        advance_head;

    fp_issue_stage u_issue (
        .clk_i, .rstn_i, .flush_i, .req_valid_i, .req_i, .ready_o,
        .tag_i         (next_tag),
        .queue_full_i  (queue_full),
        .unit_ready_i  (unit_ready),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    fp_exec_unit u_unit (
        .clk_i, .rstn_i, .flush_i,
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .unit_ready_o  (unit_ready),
        .result_o      (result)
    );

    pending_fp_ops_queue u_queue (
        .clk_i, .rstn_i, .flush_i,
        .valid_i            (issue_valid),
        .instruction_i      (issue),
        .result_valid_i     (result.valid),
        .result_tag_i       (result.tag),
        .result_data_i      (result.data),
        .result_fp_status_i (result.status),
        .advance_head_i     (advance_head),
        .finish_instr_fp_o  (finish_instr),
        .finish_fp_status_o (finish_status),
        .tag_o              (next_tag),
        .full_o             (queue_full)
    );

    fp_writeback_stage u_wb (
        .clk_i, .rstn_i, .flush_i,
        .finish_instr_i  (finish_instr),
        .finish_status_i (finish_status),
        .advance_head_o  (advance_head),
        .wb_valid_o, .wb_rd_o, .wb_data_o, .wb_status_o, .fflags_o
    );

endmodule

// ==== bench/fp_exec_tb.sv ====
// FP completion path testbench
module fp_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fp_format_pkg::*;
    import fpx_pipe_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int DRAIN_LIMIT    = 64;  // Cycles allowed to empty the pipe
    localparam int NUM_OPS        = 40;  // Upper bound over all tests
    localparam int CYCLES_PER_OP  = 12;  // Worst latency plus idle gaps
    localparam int NUM_TESTS      = 6;
    localparam int TEST_MARGIN    = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * CYCLES_PER_OP
                                    + NUM_TESTS * TEST_MARGIN;

    // Expected writeback, kept in acceptance order
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [FP_WIDTH-1:0]       data;
        fp_status_t                status;
        int                        accepted;  // Cycle of the accepting edge
    } expected_wb_t;

    logic                      clk_i = 1'b0;
    logic                      rstn_i;
    logic                      flush_i;
    logic                      req_valid_i;
    fpx_req_t                  req_i;
    logic                      ready_o;
    logic                      wb_valid_o;
    logic [REG_ADDR_WIDTH-1:0] wb_rd_o;
    logic [FP_WIDTH-1:0]       wb_data_o;
    fp_status_t                wb_status_o;
    fp_status_t                fflags_o;

    expected_wb_t expected_q [$];
    fp_status_t   flags_model;        // OR of every retired status
    integer       seed;
    int           cycle_count = 0;
    int           last_latency;
    int           retired;
    int           stall_cycles;       // Mid-cycle samples with ready_o low
    int           errors;
    int           tests_run;
    int           tests_failed;

    fp_exec_top u_dut (
        .clk_i, .rstn_i, .flush_i, .req_valid_i, .req_i, .ready_o,
        .wb_valid_o, .wb_rd_o, .wb_data_o, .wb_status_o, .fflags_o
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle_count <= cycle_count + 1;

    // Ends a hung run
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("FAILED at %t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
    endtask

    // Total order on sign-magnitude words, -0 below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    // Reference results straight from the operation rules
    task automatic model_result(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                                output logic [31:0] data, output fp_status_t status);
        logic a_nan;
        logic b_nan;
        status = '0;
        a_nan  = (a[30:23] == 8'hFF) && (a[22:0] != '0);
        b_nan  = (b[30:23] == 8'hFF) && (b[22:0] != '0);
        case (op)
            FSGNJ:   data = {b[31], a[30:0]};
            FSGNJN:  data = {~b[31], a[30:0]};
            FSGNJX:  data = {a[31] ^ b[31], a[30:0]};
            default: begin
                status.nv = (a_nan && !a[22]) || (b_nan && !b[22]);  // Signaling input
                if (a_nan && b_nan) data = 32'h7FC0_0000;
                else if (a_nan) data = b;
                else if (b_nan) data = a;
                else if (op == FMIN) data = (order_key(a) <= order_key(b)) ? a : b;
                else data = (order_key(a) >= order_key(b)) ? a : b;
            end
        endcase
    endtask

    // Offers one request from a falling edge, returns at the falling edge after acceptance
    task automatic send_op(input fp_op_e op, input logic [REG_ADDR_WIDTH-1:0] rd,
                           input logic [FP_WIDTH-1:0] a, input logic [FP_WIDTH-1:0] b);
        logic         took;
        expected_wb_t entry;
        req_i.valid = 1'b1;
        req_i.op    = op;
        req_i.rd    = rd;
        req_i.rs1   = a;
        req_i.rs2   = b;
        req_valid_i = 1'b1;
        do begin
            #(CLK_PERIOD / 4);
            took = ready_o;            // Settled well before the edge
            if (!took) stall_cycles++;
            @(negedge clk_i);
        end while (!took);
        req_valid_i = 1'b0;
        entry.rd = rd;
        model_result(op, a, b, entry.data, entry.status);
        entry.accepted = cycle_count;
        expected_q.push_back(entry);
    endtask

    // Pops one expected entry per writeback pulse
    task automatic watch_writeback();
        expected_wb_t head;
        forever begin
            @(negedge clk_i);
            if (wb_valid_o === 1'b1) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Writeback at %t to rd %0d with no operation pending",
                             $time, wb_rd_o);
                end else begin
                    head = expected_q.pop_front();
                    if (wb_rd_o !== head.rd)
                        report_mismatch("wb_rd_o", {27'b0, wb_rd_o}, {27'b0, head.rd});
                    if (wb_data_o !== head.data)
                        report_mismatch("wb_data_o", wb_data_o, head.data);
                    if (wb_status_o !== head.status)
                        report_mismatch("wb_status_o", {27'b0, wb_status_o}, {27'b0, head.status});
                    last_latency = cycle_count - head.accepted;
                    flags_model  = flags_model | head.status;
                    retired++;
                end
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("Timed out at %t with %0d writebacks missing", $time, expected_q.size());
            expected_q.delete();
        end
        repeat (2) @(negedge clk_i);  // Room for a stray duplicate
    endtask

    task automatic single_op_latency(input fp_op_e op, input logic [REG_ADDR_WIDTH-1:0] rd,
                                     input logic [31:0] a, input logic [31:0] b,
                                     input int latency);
        send_op(op, rd, a, b);
        wait_drain();
        if (last_latency != latency) report_mismatch("writeback latency", last_latency, latency);
    endtask

    task automatic check_flags();
        if (fflags_o !== flags_model)
            report_mismatch("fflags_o", {27'b0, fflags_o}, {27'b0, flags_model});
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic sign_injection_cases();
        int errors_before;
        errors_before = errors;
        single_op_latency(FSGNJ, 5'd1, $random(seed), $random(seed), 3);
        single_op_latency(FSGNJN, 5'd2, $random(seed), $random(seed), 3);
        single_op_latency(FSGNJX, 5'd3, $random(seed), $random(seed), 3);
        single_op_latency(FSGNJN, 5'd4, 32'h3F80_0000, 32'h3F80_0000, 3);  // Gives -1.0
        single_op_latency(FSGNJX, 5'd5, 32'hBF80_0000, 32'hC000_0000, 3);  // Gives +1.0
        close_test("sign injection", errors_before);
    endtask

    task automatic min_max_special_cases();
        int errors_before;
        errors_before = errors;
        single_op_latency(FMIN, 5'd6, 32'h0000_0000, 32'h8000_0000, 5);   // Mixed zeros
        single_op_latency(FMAX, 5'd7, 32'h8000_0000, 32'h0000_0000, 5);
        single_op_latency(FMIN, 5'd8, 32'h7FC0_0001, 32'h3F80_0000, 5);   // One quiet NaN
        single_op_latency(FMAX, 5'd9, 32'hC000_0000, 32'hFFC0_0000, 5);
        single_op_latency(FMIN, 5'd10, 32'h7FC0_0000, 32'hFFC1_2345, 5);  // Two quiet NaNs
        single_op_latency(FMAX, 5'd11, 32'h7F80_0001, 32'h4040_0000, 5);  // Signaling, NV
        single_op_latency(FMIN, 5'd12, 32'h7FC0_0000, 32'hFF80_0010, 5);
        single_op_latency(FMAX, 5'd13, 32'hC040_0000, 32'hBF80_0000, 5);  // Both negative
        single_op_latency(FMIN, 5'd14, 32'h7F80_0000, 32'hFF80_0000, 5);  // Infinities
        close_test("min/max special cases", errors_before);
    endtask

    // Shorts overtake longs inside the unit
    task automatic ordering_burst();
        int errors_before;
        int retired_before;
        errors_before  = errors;
        retired_before = retired;
        send_op(FMAX, 5'd16, $random(seed), $random(seed));
        send_op(FMIN, 5'd17, $random(seed), $random(seed));
        send_op(FSGNJ, 5'd18, $random(seed), $random(seed));
        send_op(FSGNJX, 5'd19, $random(seed), $random(seed));
        send_op(FMIN, 5'd20, $random(seed), $random(seed));
        send_op(FSGNJN, 5'd21, $random(seed), $random(seed));
        wait_drain();
        if (retired - retired_before != 6)
            report_mismatch("retired count", retired - retired_before, 6);
        close_test("ordering", errors_before);
    endtask

    task automatic back_pressure_burst();
        int     errors_before;
        int     retired_before;
        fp_op_e op;
        errors_before  = errors;
        retired_before = retired;
        stall_cycles   = 0;
        for (int i = 0; i < 10; i++) begin
            if (i % 2 == 0) op = FMIN;
            else op = FMAX;
            send_op(op, 5'(i + 8), $random(seed), $random(seed));  // Valid stays high
        end
        wait_drain();
        if (stall_cycles == 0) begin
            errors++;
            $display("ready_o never fell during the long-operation burst");
        end
        if (retired - retired_before != 10)
            report_mismatch("retired count", retired - retired_before, 10);
        close_test("back-pressure", errors_before);
    endtask

    task automatic flush_in_flight();
        int errors_before;
        errors_before = errors;
        send_op(FMAX, 5'd1, 32'h4000_0000, 32'h3F80_0000);
        send_op(FSGNJ, 5'd2, $random(seed), $random(seed));
        send_op(FMIN, 5'd3, 32'h7F80_0001, 32'h0000_0000);  // Still in the issue register
        flush_i = 1'b1;
        expected_q.delete();  // None of the three may retire
        #(CLK_PERIOD / 4);
        if (ready_o !== 1'b0) report_mismatch("ready_o", {31'b0, ready_o}, 32'h0);
        @(negedge clk_i);
        flush_i = 1'b0;
        repeat (8) @(negedge clk_i);
        check_flags();  // Nothing retired since the last writeback
        send_op(FSGNJN, 5'd4, $random(seed), $random(seed));
        send_op(FMAX, 5'd5, $random(seed), $random(seed));
        wait_drain();
        close_test("flush", errors_before);
    endtask

    task automatic sticky_flag_accumulation();
        int errors_before;
        errors_before = errors;
        check_flags();
        single_op_latency(FSGNJX, 5'd22, $random(seed), $random(seed), 3);
        check_flags();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        @(negedge clk_i);
        check_flags();  // Flush leaves the flags alone
        single_op_latency(FMAX, 5'd23, 32'hFF80_0001, 32'h4040_0000, 5);
        check_flags();
        if (fflags_o.nv !== 1'b1) report_mismatch("fflags_o.nv", {31'b0, fflags_o.nv}, 32'h1);
        close_test("sticky flags", errors_before);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed         = 32'h8c0fd199;
        rstn_i       = 1'b0;
        flush_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        flags_model  = '0;
        retired      = 0;
        stall_cycles = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        #(CLK_PERIOD / 4);
        if (ready_o !== 1'b1) report_mismatch("ready_o", {31'b0, ready_o}, 32'h1);
        if (wb_valid_o !== 1'b0) report_mismatch("wb_valid_o", {31'b0, wb_valid_o}, 32'h0);
        if (fflags_o !== '0) report_mismatch("fflags_o", {27'b0, fflags_o}, 32'h0);
        @(negedge clk_i);
        fork
            watch_writeback();
        join_none
        sign_injection_cases();
        min_max_special_cases();
        ordering_burst();
        back_pressure_burst();
        flush_in_flight();
        sticky_flag_accumulation();
        $display("Tests: %0d run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
logic/fp_format_pkg.sv
logic/fpx_pipe_pkg.sv
logic/fp_issue_stage.sv
logic/fp_exec_unit.sv
logic/pending_fp_ops_queue.sv
logic/fp_writeback_stage.sv
logic/fp_exec_top.sv
bench/fp_exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FP completion path testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fp_exec_tb \
    -Mdir "$BUILD_DIR" -o fp_exec_sim \
    -f files.f

"./$BUILD_DIR/fp_exec_sim" | tee "$LOG_FILE"

if grep -q "Simulation completed successfully" "$LOG_FILE"; then
    echo "Run passed"
else
    echo "Run failed, see $LOG_FILE"
    exit 1
fi
